/* tracking_output_assembly.f */
+incdir+rtl
rtl/tracking_pkg.sv
rtl/packet_buffer.sv
rtl/blob_fetch.sv
rtl/frame_writer.sv
rtl/tracking_output_assembly.sv
bench/blob_memory_model.sv
bench/tb_tracking_output_assembly.sv

/* Makefile */
# Verilator build and run for the frame assembler testbench

VERILATOR ?= verilator
TOP       ?= tb_tracking_output_assembly
FILELIST  ?= tracking_output_assembly.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_TEXT ?= All tests passed
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	$(SIM_BIN) | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_tracking_output_assembly.sv */
`timescale 1ns/10ps
`include "tracking_macros.svh"

module tb_tracking_output_assembly;

	localparam int NUM_CASES   = 8;
	localparam int CYCLE_LIMIT = NUM_CASES * 600;

	logic                   clk;
	logic                   rst;
	logic                   start;
	logic [1:0]             slide_switches;
	logic [`PTR_ADDR_W-1:0] number_of_valid_blobs;
	logic [`PTR_ADDR_W-1:0] blob_pointer_addr;
	logic [`MEM_ADDR_W-1:0] blob_pointer;
	logic [`MEM_ADDR_W-1:0] mem_addr;
	logic [`MEM_DATA_W-1:0] mem_rdata;
	logic [5:0]             frame_rd_addr;
	logic [7:0]             frame_rd_data;
	logic [5:0]             number_of_bytes_to_transmit;
	logic [7:0]             tracking_display;
	logic                   done;

	// case table, one nibble per pointer slot with slot 0 leftmost
	// nibble 0 is an invalid pointer, 1..6 a valid blob with that colour code
	string       case_name    [NUM_CASES];
	logic [1:0]  case_sw      [NUM_CASES];
	logic [4:0]  case_limit   [NUM_CASES];
	logic [79:0] case_slots   [NUM_CASES];
	logic [7:0]  case_display [NUM_CASES];
	int          n_cases = 0;

	logic [31:0] geom [`PTR_SLOTS];
	logic [7:0]  exp_frame [`FRAME_LEN_M2];
	int          exp_count;
	integer      seed;
	int          cycles = 0;
	int          errors = 0;
	int          case_errors;
	int          cases_failed = 0;

	tracking_output_assembly DUT (
		.clk                         (clk),
		.rst                         (rst),
		.start                       (start),
		.slide_switches              (slide_switches),
		.number_of_valid_blobs       (number_of_valid_blobs),
		.blob_pointer_addr           (blob_pointer_addr),
		.blob_pointer                (blob_pointer),
		.mem_addr                    (mem_addr),
		.mem_rdata                   (mem_rdata),
		.frame_rd_addr               (frame_rd_addr),
		.frame_rd_data               (frame_rd_data),
		.number_of_bytes_to_transmit (number_of_bytes_to_transmit),
		.tracking_display            (tracking_display),
		.done                        (done)
	);

	blob_memory_model blob_mem (
		.clk               (clk),
		.blob_pointer_addr (blob_pointer_addr),
		.blob_pointer      (blob_pointer),
		.mem_addr          (mem_addr),
		.mem_rdata         (mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// watchdog over the whole run
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles: done never rose", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] expected);
		if (got !== expected) begin
			$display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, expected);
			case_errors++;
			errors++;
		end
	endtask

	task automatic add_case(input string name, input logic [1:0] sw, input logic [4:0] limit,
		input logic [79:0] slots, input logic [7:0] display);
		case_name[n_cases]    = name;
		case_sw[n_cases]      = sw;
		case_limit[n_cases]   = limit;
		case_slots[n_cases]   = slots;
		case_display[n_cases] = display;
		n_cases++;
	endtask

	// pointers and records for one row, geometry drawn fresh
	task automatic load_model(input int c);
		int s;
		logic [3:0] code;
		for (s = 0; s < `PTR_SLOTS; s++) begin
			code    = case_slots[c][79 - 4*s -: 4];
			geom[s] = $random(seed);
			if (code == 4'd0)
				blob_mem.ptr_table[s] = 19'(`PTR_VALID_LO - 1 - s);	// just below the range
			else
				blob_mem.ptr_table[s] = 19'(`PTR_VALID_LO + 2*s);
			blob_mem.rec_mem[2*s]     = {24'(s), 4'd0, code};
			blob_mem.rec_mem[2*s + 1] = geom[s];
		end
	endtask

	task automatic build_expected(input int c);
		int s;
		int mode;
		int len;
		int rank;
		int k;
		int stride;
		int size_base;
		int pos;
		int size_pos;
		int accepted;
		logic stop;
		logic [3:0] code;
		mode = (case_sw[c] == 2'b01) ? 1 : (case_sw[c] == 2'b10) ? 2 : 0;
		exp_count = 0;
		if (mode != 0) begin
			len       = (mode == 1) ? `FRAME_LEN_M1 : `FRAME_LEN_M2;
			stride    = (mode == 1) ? 6 : 12;
			size_base = (mode == 1) ? `SIZE_BASE_M1 : `SIZE_BASE_M2;
			exp_count = len;
			for (s = 0; s < `FRAME_LEN_M2; s++)
				exp_frame[s] = 8'h00;
			exp_frame[0]       = `FRAME_MARK;
			exp_frame[1]       = 8'(mode);
			exp_frame[len - 2] = `FRAME_LF;
			exp_frame[len - 1] = `FRAME_CR;
			accepted = 0;
			stop = (case_limit[c] == 0);
			for (s = 0; s < `PTR_SLOTS && !stop; s++) begin
				code = case_slots[c][79 - 4*s -: 4];
				rank = (s < `RANK2_FIRST_SLOT) ? 1 : (s < `RANK3_FIRST_SLOT) ? 2 : 3;
				if (code != 4'd0 && rank == 3) begin
					stop = 1'b1;
				end else if (code != 4'd0) begin
					k = code - 1;
					if (mode == 1)
						k = (code == 1) ? 0 : (code == 4) ? 1 : (code == 5) ? 2 : -1;
					if (k >= 0) begin	// later blobs overwrite earlier ones
						pos      = `GEOM_BASE + stride * (rank - 1) + 2 * k;
						size_pos = size_base + stride * (rank - 1) + 2 * k;
						exp_frame[pos]          = geom[s][31:24];
						exp_frame[pos + 1]      = geom[s][23:16];
						exp_frame[size_pos]     = geom[s][15:8];
						exp_frame[size_pos + 1] = geom[s][7:0];
					end
					accepted++;
					if (accepted == case_limit[c])
						stop = 1'b1;
				end
			end
		end
	endtask

	task automatic start_and_wait(input int c);
		@(posedge clk);
		#1;
		slide_switches        = case_sw[c];
		number_of_valid_blobs = case_limit[c];
		start                 = 1'b1;
		@(posedge clk);
		#1;
		start          = 1'b0;
		slide_switches = ~case_sw[c];	// mode must already be latched
		while (done !== 1'b1) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic read_frame();
		int i;
		for (i = 0; i < `FRAME_LEN_M2; i++) begin
			frame_rd_addr = 6'(i);
			@(posedge clk);
			#1;
			check_value($sformatf("frame byte %0d", i), frame_rd_data, exp_frame[i]);
		end
	endtask

	initial begin
		int c;
		rst                   = 1'b1;
		start                 = 1'b0;
		slide_switches        = 2'b00;
		number_of_valid_blobs = '0;
		frame_rd_addr         = '0;
		seed                  = 97177;

		add_case("mode 1 mix",        2'b01, 5'd20, 80'h1435_0140_5310_0000_0000, 8'h1d);
		add_case("mode 2 full",       2'b10, 5'd20, 80'h1234_5665_4321_0216_0000, 8'h3f);
		add_case("mode 1 after 2",    2'b01, 5'd20, 80'h0500_0004_0000_1500_0000, 8'h18);
		add_case("blob limit",        2'b01, 5'd3,  80'h4013_5140_0000_0000_0000, 8'h0d);
		add_case("limit on written",  2'b10, 5'd2,  80'h2600_3000_0000_0000_0000, 8'h22);
		add_case("switches 00",       2'b00, 5'd20, 80'h1234_5665_4321_0216_0000, 8'h00);
		add_case("switches 11",       2'b11, 5'd20, 80'h1234_5665_4321_0216_0000, 8'h00);
		add_case("limit of zero",     2'b10, 5'd0,  80'h1111_1111_1111_0000_0000, 8'h00);

		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		for (c = 0; c < n_cases; c++) begin
			case_errors = 0;
			load_model(c);
			build_expected(c);
			start_and_wait(c);
			check_value("byte count", number_of_bytes_to_transmit, exp_count);
			read_frame();
			check_value("display", tracking_display, case_display[c]);
			if (case_errors != 0)
				cases_failed++;
			$display("case %0d %s: %s", c, case_name[c], (case_errors == 0) ? "ok" : "FAIL");
		end

		$display("%0d cases, %0d ok, %0d failed, %0d mismatches", n_cases,
			n_cases - cases_failed, cases_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* bench/blob_memory_model.sv */
`timescale 1ns/10ps
`include "tracking_macros.svh"

// pointer table and blob records, both read with one cycle of latency
module blob_memory_model (
	input  logic                   clk,
	input  logic [`PTR_ADDR_W-1:0] blob_pointer_addr,
	output logic [`MEM_ADDR_W-1:0] blob_pointer,
	input  logic [`MEM_ADDR_W-1:0] mem_addr,
	output logic [`MEM_DATA_W-1:0] mem_rdata
);

	logic [`MEM_ADDR_W-1:0] ptr_table [0:`PTR_SLOTS-1];

	// records start at 200000, a multiple of 64, so the low six address bits pick the word
	logic [`MEM_DATA_W-1:0] rec_mem [0:63];

	always_ff @(posedge clk) begin
		blob_pointer <= ptr_table[blob_pointer_addr];
		mem_rdata    <= rec_mem[mem_addr[5:0]];
	end

endmodule

/* rtl/tracking_output_assembly.sv */
`timescale 1ns/10ps
`include "tracking_macros.svh"

module tracking_output_assembly (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          start,
	input  logic [1:0]                    slide_switches,
	input  logic [`PTR_ADDR_W-1:0]        number_of_valid_blobs,
	output logic [`PTR_ADDR_W-1:0]        blob_pointer_addr,
	input  logic [`MEM_ADDR_W-1:0]        blob_pointer,
	output logic [`MEM_ADDR_W-1:0]        mem_addr,
	input  logic [`MEM_DATA_W-1:0]        mem_rdata,
	input  tracking_pkg::frame_addr_t     frame_rd_addr,
	output tracking_pkg::frame_byte_t     frame_rd_data,
	output tracking_pkg::frame_addr_t     number_of_bytes_to_transmit,
	output logic [7:0]                    tracking_display,
	output logic                          done
);

	tracking_pkg::track_mode_t mode;
	logic scan_start;
	logic scan_done;

	// blob handoff from fetch to writer
	logic                      blob_valid;
	logic                      blob_ready;
	tracking_pkg::blob_rank_t  blob_rank;
	tracking_pkg::blob_color_t blob_color;
	tracking_pkg::blob_geom_t  blob_geom;

	// frame buffer write side
	logic                      wr_en;
	tracking_pkg::frame_addr_t wr_addr;
	tracking_pkg::frame_byte_t wr_data;

	frame_writer u_frame_writer (
		.clk                         (clk),
		.rst                         (rst),
		.start                       (start),
		.slide_switches              (slide_switches),
		.scan_done                   (scan_done),
		.blob_valid                  (blob_valid),
		.blob_rank                   (blob_rank),
		.blob_color                  (blob_color),
		.blob_geom                   (blob_geom),
		.mode                        (mode),
		.scan_start                  (scan_start),
		.blob_ready                  (blob_ready),
		.wr_en                       (wr_en),
		.wr_addr                     (wr_addr),
		.wr_data                     (wr_data),
		.number_of_bytes_to_transmit (number_of_bytes_to_transmit),
		.done                        (done)
	);

	blob_fetch u_blob_fetch (
		.clk                   (clk),
		.rst                   (rst),
		.scan_start            (scan_start),
		.mode                  (mode),
		.number_of_valid_blobs (number_of_valid_blobs),
		.blob_pointer          (blob_pointer),
		.mem_rdata             (mem_rdata),
		.blob_ready            (blob_ready),
		.blob_pointer_addr     (blob_pointer_addr),
		.mem_addr              (mem_addr),
		.blob_valid            (blob_valid),
		.blob_rank             (blob_rank),
		.blob_color            (blob_color),
		.blob_geom             (blob_geom),
		.scan_done             (scan_done),
		.tracking_display      (tracking_display)
	);

	packet_buffer u_packet_buffer (
		.clk     (clk),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.rd_addr (frame_rd_addr),
		.rd_data (frame_rd_data)
	);

endmodule

/* rtl/frame_writer.sv */
`timescale 1ns/10ps
`include "tracking_macros.svh"

module frame_writer (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          start,
	input  logic [1:0]                    slide_switches,
	input  logic                          scan_done,
	input  logic                          blob_valid,
	input  tracking_pkg::blob_rank_t      blob_rank,
	input  tracking_pkg::blob_color_t     blob_color,
	input  tracking_pkg::blob_geom_t      blob_geom,
	output tracking_pkg::track_mode_t     mode,
	output logic                          scan_start,
	output logic                          blob_ready,
	output logic                          wr_en,
	output tracking_pkg::frame_addr_t     wr_addr,
	output tracking_pkg::frame_byte_t     wr_data,
	output tracking_pkg::frame_addr_t     number_of_bytes_to_transmit,
	output logic                          done
);

	typedef enum logic [2:0] {S_IDLE, S_CLEAR, S_HDR, S_SCAN, S_BLOB} fw_state_t;

	fw_state_t state;
	tracking_pkg::frame_addr_t step;		// clear address, header or blob byte index
	tracking_pkg::track_mode_t run_mode;
	tracking_pkg::track_mode_t sw_mode;
	tracking_pkg::blob_geom_t  geom_q;
	tracking_pkg::frame_addr_t y_addr_q;
	tracking_pkg::frame_addr_t size_addr_q;
	logic scan_end;		// scan finished while a blob was still being written

	logic skip;
	logic [2:0] k_idx;
	tracking_pkg::frame_addr_t rank_off;
	tracking_pkg::frame_addr_t col_off;
	tracking_pkg::frame_addr_t size_base;
	tracking_pkg::frame_addr_t pos_addr;
	tracking_pkg::frame_addr_t size_addr;

	assign sw_mode = tracking_pkg::decode_mode(slide_switches);
	assign blob_ready = (state == S_SCAN);

	// slot map for the offered blob
	always_comb begin
		skip  = 1'b0;
		k_idx = blob_color;
		if (run_mode == tracking_pkg::MODE_1) begin
			case (blob_color)
				tracking_pkg::RED:   k_idx = 3'd0;
				tracking_pkg::GREEN: k_idx = 3'd1;
				tracking_pkg::BLUE:  k_idx = 3'd2;
				default:             skip  = 1'b1;	// no slot in mode 1
			endcase
		end else if (blob_color > tracking_pkg::PURPLE) begin
			skip = 1'b1;
		end
		if (blob_rank == 2'd2)
			rank_off = (run_mode == tracking_pkg::MODE_2) ? 6'd12 : 6'd6;
		else
			rank_off = 6'd0;
		col_off   = 6'({k_idx, 1'b0});
		size_base = (run_mode == tracking_pkg::MODE_2) ? 6'(`SIZE_BASE_M2) : 6'(`SIZE_BASE_M1);
		pos_addr  = 6'(`GEOM_BASE) + rank_off + col_off;
		size_addr = size_base + rank_off + col_off;
	end

	always_ff @(posedge clk) begin
		wr_en      <= 1'b0;
		scan_start <= 1'b0;
		if (rst) begin
			state    <= S_IDLE;
			done     <= 1'b0;
			mode     <= tracking_pkg::MODE_NONE;
			run_mode <= tracking_pkg::MODE_NONE;
			step     <= '0;
			scan_end <= 1'b0;
			number_of_bytes_to_transmit <= '0;
		end else begin
			if (scan_done)
				scan_end <= 1'b1;
			case (state)
				S_IDLE: begin
					if (start) begin
						mode     <= tracking_pkg::MODE_NONE;	// held until the scan begins
						run_mode <= sw_mode;
						step     <= '0;
						scan_end <= 1'b0;
						case (sw_mode)
							tracking_pkg::MODE_1: begin
								number_of_bytes_to_transmit <= 6'(`FRAME_LEN_M1);
								done  <= 1'b0;
								state <= S_CLEAR;
							end
							tracking_pkg::MODE_2: begin
								number_of_bytes_to_transmit <= 6'(`FRAME_LEN_M2);
								done  <= 1'b0;
								state <= S_CLEAR;
							end
							default: begin
								number_of_bytes_to_transmit <= '0;
								done <= 1'b1;		// nothing to assemble
							end
						endcase
					end
				end
				S_CLEAR: begin
					wr_en   <= 1'b1;
					wr_addr <= step;
					wr_data <= '0;
					step    <= step + 1'b1;
					if (step == 6'(`FRAME_LEN_M2 - 1)) begin
						step  <= '0;
						state <= S_HDR;
					end
				end
				S_HDR: begin
					wr_en <= 1'b1;
					step  <= step + 1'b1;
					case (step[1:0])
						2'd0: begin
							wr_addr <= 6'd0;
							wr_data <= 8'(`FRAME_MARK);
						end
						2'd1: begin
							wr_addr <= 6'd1;
							wr_data <= 8'(run_mode);	// protocol version is the mode number
						end
						2'd2: begin
							wr_addr <= number_of_bytes_to_transmit - 6'd2;
							wr_data <= 8'(`FRAME_LF);
						end
						default: begin
							wr_addr    <= number_of_bytes_to_transmit - 6'd1;
							wr_data    <= 8'(`FRAME_CR);
							mode       <= run_mode;
							scan_start <= 1'b1;
							state      <= S_SCAN;
						end
					endcase
				end
				S_SCAN: begin
					if (scan_done || scan_end) begin
						done  <= 1'b1;
						state <= S_IDLE;
					end else if (blob_valid && !skip) begin
						// x goes out in the transfer cycle
						wr_en       <= 1'b1;
						wr_addr     <= pos_addr;
						wr_data     <= blob_geom.x;
						geom_q      <= blob_geom;
						y_addr_q    <= pos_addr + 6'd1;
						size_addr_q <= size_addr;
						step        <= '0;
						state       <= S_BLOB;
					end
				end
				S_BLOB: begin
					wr_en <= 1'b1;
					step  <= step + 1'b1;
					case (step[1:0])
						2'd0: begin
							wr_addr <= y_addr_q;
							wr_data <= geom_q.y;
						end
						2'd1: begin
							wr_addr <= size_addr_q;
							wr_data <= geom_q.size_hi;
						end
						default: begin
							wr_addr <= size_addr_q + 6'd1;
							wr_data <= geom_q.size_lo;
							state   <= S_SCAN;
						end
					endcase
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	a_wr_in_frame: assert property (@(posedge clk) disable iff (rst)
		wr_en |-> wr_addr < 6'(`FRAME_LEN_M2));

endmodule

/* rtl/blob_fetch.sv */
`timescale 1ns/10ps
`include "tracking_macros.svh"

module blob_fetch (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          scan_start,
	input  tracking_pkg::track_mode_t     mode,
	input  logic [`PTR_ADDR_W-1:0]        number_of_valid_blobs,
	input  logic [`MEM_ADDR_W-1:0]        blob_pointer,
	input  logic [`MEM_DATA_W-1:0]        mem_rdata,
	input  logic                          blob_ready,
	output logic [`PTR_ADDR_W-1:0]        blob_pointer_addr,
	output logic [`MEM_ADDR_W-1:0]        mem_addr,
	output logic                          blob_valid,
	output tracking_pkg::blob_rank_t      blob_rank,
	output tracking_pkg::blob_color_t     blob_color,
	output tracking_pkg::blob_geom_t      blob_geom,
	output logic                          scan_done,
	output logic [7:0]                    tracking_display
);

	typedef enum logic [2:0] {
		F_IDLE, F_PTR_WAIT, F_PTR_CHK, F_REC0, F_REC1, F_REC2, F_OFFER
	} fetch_state_t;

	fetch_state_t state;
	logic [`PTR_ADDR_W-1:0] nvb_q;		// blob limit for this run
	logic [`PTR_ADDR_W-1:0] accepted;
	logic [`PTR_ADDR_W-1:0] accepted_next;
	logic ptr_ok;
	logic last_slot;
	logic [7:0] color_m1;
	tracking_pkg::blob_rank_t slot_rank;

	assign ptr_ok = (32'(blob_pointer) >= `PTR_VALID_LO) && (32'(blob_pointer) < `PTR_VALID_HI);
	assign last_slot = (blob_pointer_addr == `PTR_ADDR_W'(`PTR_SLOTS - 1));
	assign accepted_next = accepted + 1'b1;
	assign color_m1 = mem_rdata[7:0] - 8'd1;

	// rank follows the slot index
	assign slot_rank = (blob_pointer_addr < `PTR_ADDR_W'(`RANK2_FIRST_SLOT)) ? 2'd1 :
		(blob_pointer_addr < `PTR_ADDR_W'(`RANK3_FIRST_SLOT)) ? 2'd2 : 2'd3;

	always_ff @(posedge clk) begin
		scan_done <= 1'b0;
		if (rst) begin
			state             <= F_IDLE;
			blob_valid        <= 1'b0;
			blob_pointer_addr <= '0;
			accepted          <= '0;
			nvb_q             <= '0;
			tracking_display  <= '0;
		end else begin
			case (state)
				F_IDLE: begin
					// writer holds mode at MODE_NONE from start until the scan
					if (mode == tracking_pkg::MODE_NONE)
						tracking_display <= '0;
					if (scan_start) begin
						nvb_q             <= number_of_valid_blobs;
						accepted          <= '0;
						blob_pointer_addr <= '0;
						if (number_of_valid_blobs == '0)
							scan_done <= 1'b1;
						else
							state <= F_PTR_WAIT;
					end
				end
				F_PTR_WAIT: state <= F_PTR_CHK;	// pointer table latency
				F_PTR_CHK: begin
					if (!ptr_ok) begin
						if (last_slot) begin
							scan_done <= 1'b1;
							state     <= F_IDLE;
						end else begin
							blob_pointer_addr <= blob_pointer_addr + 1'b1;
							state             <= F_PTR_WAIT;
						end
					end else if (slot_rank == 2'd3) begin
						scan_done <= 1'b1;	// rank 3 ends the run
						state     <= F_IDLE;
					end else begin
						mem_addr  <= blob_pointer;
						blob_rank <= slot_rank;
						state     <= F_REC0;
					end
				end
				F_REC0: begin
					mem_addr <= mem_addr + 1'b1;
					state    <= F_REC1;
				end
				F_REC1: begin
					// codes outside 1..6 map to 7 so the writer drops them
					if (color_m1 > 8'd5)
						blob_color <= tracking_pkg::blob_color_t'(3'd7);
					else
						blob_color <= tracking_pkg::blob_color_t'(color_m1[2:0]);
					state <= F_REC2;
				end
				F_REC2: begin
					blob_geom  <= tracking_pkg::blob_geom_t'(mem_rdata);
					blob_valid <= 1'b1;
					state      <= F_OFFER;
				end
				F_OFFER: begin
					if (blob_ready) begin
						blob_valid <= 1'b0;
						accepted   <= accepted_next;
						if (blob_color <= tracking_pkg::PURPLE)
							tracking_display[blob_color] <= 1'b1;
						if (accepted_next == nvb_q || last_slot) begin
							scan_done <= 1'b1;
							state     <= F_IDLE;
						end else begin
							blob_pointer_addr <= blob_pointer_addr + 1'b1;
							state             <= F_PTR_WAIT;
						end
					end
				end
				default: state <= F_IDLE;
			endcase
		end
	end

	// offered blob must not change under back-pressure
	a_blob_stable: assert property (@(posedge clk) disable iff (rst)
		blob_valid && !blob_ready |=> blob_valid && $stable(blob_rank) &&
			$stable(blob_color) && $stable(blob_geom));

endmodule

/* rtl/packet_buffer.sv */
`timescale 1ns/10ps

// frame store, written by the assembler and read by the transmitter
module packet_buffer (
	input  logic                      clk,
	input  logic                      wr_en,
	input  tracking_pkg::frame_addr_t wr_addr,
	input  tracking_pkg::frame_byte_t wr_data,
	input  tracking_pkg::frame_addr_t rd_addr,
	output tracking_pkg::frame_byte_t rd_data
);

	tracking_pkg::frame_byte_t mem [0:63];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// registered read, data one cycle after the address
	always_ff @(posedge clk) begin
		rd_data <= mem[rd_addr];
	end

endmodule

/* rtl/tracking_pkg.sv */
package tracking_pkg;

	// switch settings 00 and 11 both decode to MODE_NONE
	typedef enum logic [1:0] {
		MODE_NONE = 2'd0,
		MODE_1    = 2'd1,	// r/g/b, ranks 1-2, 28 bytes
		MODE_2    = 2'd2	// six colours, ranks 1-2, 52 bytes
	} track_mode_t;

	// record colour byte minus one
	typedef enum logic [2:0] {
		RED    = 3'd0,
		ORANGE = 3'd1,
		YELLOW = 3'd2,
		GREEN  = 3'd3,
		BLUE   = 3'd4,
		PURPLE = 3'd5
	} blob_color_t;

	typedef logic [1:0] blob_rank_t;	// 1..3
	typedef logic [5:0] frame_addr_t;
	typedef logic [7:0] frame_byte_t;

	// record word 1, x in the top byte
	typedef struct packed {
		frame_byte_t x;
		frame_byte_t y;
		frame_byte_t size_hi;
		frame_byte_t size_lo;
	} blob_geom_t;

	function automatic track_mode_t decode_mode(input logic [1:0] sw);
		case (sw)
			2'b01:   return MODE_1;
			2'b10:   return MODE_2;
			default: return MODE_NONE;
		endcase
	endfunction

endpackage

/* rtl/tracking_macros.svh */
`ifndef TRACKING_MACROS_SVH
`define TRACKING_MACROS_SVH

// main memory
`define MEM_ADDR_W 19
`define MEM_DATA_W 32

// pointer table
`define PTR_SLOTS 20
`define PTR_ADDR_W 5
`define PTR_VALID_LO 200000
`define PTR_VALID_HI 524288

// rank boundaries by slot index
`define RANK2_FIRST_SLOT 6
`define RANK3_FIRST_SLOT 12

// frame bytes
`define FRAME_MARK 176
`define FRAME_LF 10
`define FRAME_CR 13

// frame lengths
`define FRAME_LEN_M1 28
`define FRAME_LEN_M2 52

// slot bases for position and size bytes
`define GEOM_BASE 2
`define SIZE_BASE_M1 14
`define SIZE_BASE_M2 26

`endif
